//--- Makefile
VERILATOR  ?= verilator
TOP        := sms_support_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
RUN_ARGS   := +verilator+error+limit+100
FAIL_MSG   := RESULT: FAIL
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) hdl/sms_settings.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/backup_ram_sequencer.sv
`timescale 1ns/100ps
`include "sms_settings.svh"

module backup_ram_sequencer (
	input  logic             clk_sys,
	input  logic             RESET,
	input  sms_pkg::dl_bus_t dl,
	input  logic             img_mounted,
	input  logic             img_readonly,
	input  logic             img_size_nonzero,
	input  logic             nvram_we,
	input  logic             osd_open,
	input  logic             autosave,
	input  logic             load_req,
	input  logic             save_req,
	input  logic             sd_ack,
	output sms_pkg::sd_req_t sd,
	output logic             bk_busy,
	output logic             bk_loading,
	output logic             bk_pending
);

	import sms_pkg::*;

	bk_state_t state;
	logic      bk_ena;
	logic      cart_dl;
	logic      cart_dl_q;
	logic      ack_q;
	logic      ack_rise;
	logic      ack_fall;
	logic      load_cond;
	logic      save_cond;
	logic      load_q;
	logic      save_q;
	logic      start_load;
	logic      start_save;
	logic      last_sector;

	// Anything but cheats, system mode and DIP switches is a cartridge
	assign cart_dl = dl.active && (dl.index != `DL_INDEX_CHEAT) &&
		(dl.index != `DL_INDEX_SYSMODE) && (dl.index != `DL_INDEX_DIPSW);

	assign load_cond = load_req && bk_ena;
	assign save_cond = (save_req || (bk_pending && osd_open && autosave)) && bk_ena;

	// A finished cartridge download pulls in its save image
	assign start_load = (load_cond && !load_q) ||
		(cart_dl_q && !cart_dl && img_size_nonzero && bk_ena);
	assign start_save = save_cond && !save_q;

	assign ack_rise    = sd_ack && !ack_q;
	assign ack_fall    = !sd_ack && ack_q;
	assign last_sector = (sd.lba == lba_t'(`BK_SECTOR_COUNT - 1));
	assign bk_busy     = (state != BK_IDLE);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
			ack_q     <= 1'b0;
			load_q    <= 1'b0;
			save_q    <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			ack_q     <= sd_ack;
			load_q    <= load_cond;
			save_q    <= save_cond;
		end
	end

	// ======================================================================
	// Backup enable and pending flag
	// ======================================================================

	// Image gets mounted while the cartridge is still downloading
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena <= 1'b0;
		end else begin
			if (cart_dl && !cart_dl_q)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_open && nvram_we) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	// ======================================================================
	// Sector walk
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			sd.rd      <= 1'b0;
			sd.wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				BK_IDLE: begin
					// Load wins when both fire together
					if (start_load || start_save) begin
						state      <= BK_WAIT_ACK;
						bk_loading <= start_load;
						sd.rd      <= start_load;
						sd.wr      <= !start_load;
						sd.lba     <= '0;
					end
				end
				BK_WAIT_ACK: begin
					if (ack_rise) begin
						sd.rd <= 1'b0;
						sd.wr <= 1'b0;
						state <= BK_XFER;
					end
				end
				BK_XFER: begin
					// Host drops ack once the sector buffer is done
					if (ack_fall) begin
						if (last_sector) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd.lba <= sd.lba + lba_t'(1);
							sd.rd  <= bk_loading;
							sd.wr  <= !bk_loading;
							state  <= BK_WAIT_ACK;
						end
					end
				end
				default: begin
					state <= BK_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hdl/cheat_code_loader.sv
`timescale 1ns/100ps
`include "sms_settings.svh"

module cheat_code_loader (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  sms_pkg::dl_bus_t     dl,
	output sms_pkg::cheat_code_t cheat_code,
	output logic                 cheat_valid,
	output logic                 cheat_clear
);

	logic       code_wr;
	logic [1:0] lane;
	logic       last_byte;
	logic       first_byte;

	assign code_wr    = dl.active && dl.wr && (dl.index == `DL_INDEX_CHEAT);
	assign lane       = dl.addr[1:0];
	assign last_byte  = (dl.addr[3:0] == 4'(`CHEAT_RECORD_BYTES - 1));
	assign first_byte = dl.active && dl.wr && (dl.addr == '0);

	// ======================================================================
	// Record assembly
	// ======================================================================

	// Nibble bits 3:2 pick the field, bits 1:0 the byte, LSB first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:2])
				2'd0: cheat_code.flags[8*lane +: 8]   <= dl.data;
				2'd1: cheat_code.address[8*lane +: 8] <= dl.data;
				2'd2: cheat_code.compare[8*lane +: 8] <= dl.data;
				default: cheat_code.replace[8*lane +: 8] <= dl.data;
			endcase
		end
	end

	// ======================================================================
	// Strobes
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
		end else begin
			// Record is complete once the last byte has landed
			cheat_valid <= code_wr && last_byte;
		end
	end

	// Any new download wipes the cheat list
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_clear <= 1'b0;
		end else begin
			cheat_clear <= first_byte;
		end
	end

endmodule

//--- hdl/clock_enable_gen.sv
`timescale 1ns/100ps
`include "sms_settings.svh"

module clock_enable_gen (
	input  logic             clk_sys,
	input  logic             RESET,
	output sms_pkg::ce_bus_t ce
);

	// Position inside the enable frame
	logic [4:0] phase;
	logic       frame_end;

	assign frame_end = (phase == 5'(`CE_CYCLE_LEN - 1));

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			phase <= '0;
		end else if (frame_end) begin
			phase <= '0;
		end else begin
			phase <= phase + 5'd1;
		end
	end

	// ======================================================================
	// Enable decode with one pulse per listed phase
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ce <= '0;
		end else begin
			// Frame length is even, so sp keeps its period across the wrap
			ce.sp  <= phase[0];
			ce.vdp <= 1'b0;
			ce.pix <= 1'b0;
			ce.cpu <= 1'b0;
			case (phase)
				5'd4, 5'd14: begin
					ce.vdp <= 1'b1;
				end
				5'd9: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
					ce.cpu <= 1'b1;
				end
				5'd19, 5'd29: begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				// Late cpu phase keeps the H counter timing
				5'd24: begin
					ce.vdp <= 1'b1;
					ce.cpu <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

//--- hdl/sms_pkg.sv
package sms_pkg;

	// Widths with a meaning of their own
	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [31:0] lba_t;

	// Download stream from the host
	typedef struct packed {
		logic      active;
		logic      wr;
		dl_index_t index;
		dl_addr_t  addr;
		byte_t     data;
	} dl_bus_t;

	// Core clock enables
	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} ce_bus_t;

	// One cheat record with flags in the top word
	typedef struct packed {
		word_t flags;
		word_t address;
		word_t compare;
		word_t replace;
	} cheat_code_t;

	// Sector request to the host
	typedef struct packed {
		logic rd;
		logic wr;
		lba_t lba;
	} sd_req_t;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_WAIT_ACK,
		BK_XFER
	} bk_state_t;

endpackage

//--- hdl/sms_settings.svh
`ifndef SMS_SETTINGS_SVH
`define SMS_SETTINGS_SVH

// ======================================================================
// Clock enables
// ======================================================================

// Length of one enable frame in clk_sys cycles
`define CE_CYCLE_LEN 30

// ======================================================================
// Backup RAM
// ======================================================================

// One backup image is this many 512-byte sectors
`define BK_SECTOR_COUNT 64

// ======================================================================
// Download stream
// ======================================================================

// Targets that are not cartridge images
`define DL_INDEX_CHEAT   8'hFF
`define DL_INDEX_SYSMODE 8'd4
`define DL_INDEX_DIPSW   8'd254

// Size of one cheat record on the stream
`define CHEAT_RECORD_BYTES 16

`endif

//--- hdl/sms_support_top.sv
`timescale 1ns/100ps

module sms_support_top (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  sms_pkg::dl_bus_t     dl,
	output sms_pkg::ce_bus_t     ce,
	output sms_pkg::cheat_code_t cheat_code,
	output logic                 cheat_valid,
	output logic                 cheat_clear,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic                 img_size_nonzero,
	input  logic                 nvram_we,
	input  logic                 osd_open,
	input  logic                 autosave,
	input  logic                 load_req,
	input  logic                 save_req,
	input  logic                 sd_ack,
	output sms_pkg::sd_req_t     sd,
	output logic                 bk_busy,
	output logic                 bk_loading,
	output logic                 bk_pending
);

	clock_enable_gen u_clock_enable_gen (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ce      (ce)
	);

	// Both loaders watch the same download stream
	cheat_code_loader u_cheat_code_loader (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	backup_ram_sequencer u_backup_ram_sequencer (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.dl               (dl),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.img_size_nonzero (img_size_nonzero),
		.nvram_we         (nvram_we),
		.osd_open         (osd_open),
		.autosave         (autosave),
		.load_req         (load_req),
		.save_req         (save_req),
		.sd_ack           (sd_ack),
		.sd               (sd),
		.bk_busy          (bk_busy),
		.bk_loading       (bk_loading),
		.bk_pending       (bk_pending)
	);

endmodule

//--- src.f
+incdir+hdl
hdl/sms_pkg.sv
hdl/clock_enable_gen.sv
hdl/cheat_code_loader.sv
hdl/backup_ram_sequencer.sv
hdl/sms_support_top.sv
verif/sms_support_assert.sv
verif/sms_support_tb.sv

//--- verif/sms_support_assert.sv
`timescale 1ns/100ps

module sms_support_assert (
	input logic             clk_sys,
	input logic             RESET,
	input sms_pkg::ce_bus_t ce,
	input sms_pkg::sd_req_t sd,
	input logic             bk_busy
);

	int unsigned rd_wr_fails = 0;
	int unsigned idle_req_fails = 0;
	int unsigned cpu_fails = 0;
	int unsigned pix_fails = 0;
	int unsigned fail_count;

	assign fail_count = rd_wr_fails + idle_req_fails + cpu_fails + pix_fails;

	// ======================================================================
	// Sector requests
	// ======================================================================

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd.rd && sd.wr))
	else begin
		rd_wr_fails++;
		$error("sd.rd and sd.wr high together");
	end

	a_req_busy: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd.rd || sd.wr) |-> bk_busy)
	else begin
		idle_req_fails++;
		$error("Sector request while bk_busy is low");
	end

	// ======================================================================
	// Clock enables
	// ======================================================================

	a_cpu_vdp: assert property (@(posedge clk_sys) disable iff (RESET)
		ce.cpu |-> ce.vdp)
	else begin
		cpu_fails++;
		$error("ce.cpu without ce.vdp");
	end

	a_pix_vdp: assert property (@(posedge clk_sys) disable iff (RESET)
		ce.pix |-> ce.vdp)
	else begin
		pix_fails++;
		$error("ce.pix without ce.vdp");
	end

endmodule

bind sms_support_top sms_support_assert u_assert (.*);

//--- verif/sms_support_tb.sv
`timescale 1ns/100ps
`include "sms_settings.svh"

module sms_support_tb;

	import sms_pkg::*;

	logic        clk_sys;
	logic        RESET;
	dl_bus_t     dl;
	ce_bus_t     ce;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_clear;
	logic        img_mounted;
	logic        img_readonly;
	logic        img_size_nonzero;
	logic        nvram_we;
	logic        osd_open;
	logic        autosave;
	logic        load_req;
	logic        save_req;
	logic        sd_ack;
	sd_req_t     sd;
	logic        bk_busy;
	logic        bk_loading;
	logic        bk_pending;

	integer      seed;
	integer      ack_seed;
	int          ack_delay = 0;
	int          ack_hold = 0;
	sd_req_t     req_log[$];
	cheat_code_t model_code;

	sms_support_top dut (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// ======================================================================
	// Common helpers
	// ======================================================================

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Next rising edge, then settle 1 ns so outputs are stable
	task automatic step();
		@(posedge clk_sys);
		#1;
		if (dut.u_assert.fail_count != 0) begin
			$display("A bound assertion on the DUT failed at %0t", $time);
			abort_run();
		end
	endtask

	task automatic check_ce(input ce_bus_t got, input ce_bus_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_code(input cheat_code_t got, input cheat_code_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_req(input sd_req_t got, input sd_req_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got rd=%b wr=%b lba=%0d expected rd=%b wr=%b lba=%0d",
				$time, what, got.rd, got.wr, got.lba, exp.rd, exp.wr, exp.lba);
			abort_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (bk_busy !== level) begin
			if (n >= limit) begin
				$display("Timeout after %0d cycles waiting for bk_busy to become %b",
					limit, level);
				abort_run();
			end
			step();
			n++;
		end
	endtask

	// ======================================================================
	// Download stream
	// ======================================================================

	// Idle cycles in which no cheat strobe may fire
	task automatic idle_gap(input int n);
		for (int i = 0; i < n; i++) begin
			step();
			check_flag(cheat_valid, 1'b0, "cheat_valid between writes");
			check_flag(cheat_clear, 1'b0, "cheat_clear between writes");
		end
	endtask

	task automatic dl_write(input dl_index_t index, input dl_addr_t addr, input byte_t data);
		int   k;
		logic exp_valid;
		k = int'(addr) % `CHEAT_RECORD_BYTES;
		dl.wr    = 1'b1;
		dl.index = index;
		dl.addr  = addr;
		dl.data  = data;
		// Field k/4 with flags first, byte k%4 LSB first
		if (index == `DL_INDEX_CHEAT)
			model_code[(3 - k / 4) * 32 + (k % 4) * 8 +: 8] = data;
		exp_valid = (index == `DL_INDEX_CHEAT) && (k == `CHEAT_RECORD_BYTES - 1);
		step();
		dl.wr = 1'b0;
		check_flag(cheat_valid, exp_valid, "cheat_valid after write");
		check_flag(cheat_clear, addr == '0, "cheat_clear after write");
		if (exp_valid)
			check_code(cheat_code, model_code, "cheat record");
	endtask

	task automatic download(input dl_index_t index, input int nbytes);
		dl.active = 1'b1;
		dl.index  = index;
		idle_gap(1);
		for (int a = 0; a < nbytes; a++) begin
			idle_gap($unsigned($random(seed)) % 4);
			dl_write(index, dl_addr_t'(a), byte_t'($random(seed)));
		end
		dl.active = 1'b0;
	endtask

	// ======================================================================
	// Backup transfers
	// ======================================================================

	task automatic expect_transfer(input logic is_read);
		sd_req_t exp;
		wait_busy(1'b1, 20);
		check_flag(bk_loading, is_read, "bk_loading at transfer start");
		wait_busy(1'b0, `BK_SECTOR_COUNT * 16);
		check_flag(bk_loading, 1'b0, "bk_loading after transfer");
		if (req_log.size() != `BK_SECTOR_COUNT) begin
			$display("Host saw %0d sector requests instead of %0d",
				req_log.size(), `BK_SECTOR_COUNT);
			abort_run();
		end
		for (int k = 0; k < `BK_SECTOR_COUNT; k++) begin
			exp.rd  = is_read;
			exp.wr  = !is_read;
			exp.lba = lba_t'(k);
			check_req(req_log[k], exp, "sector request");
		end
		req_log.delete();
	endtask

	task automatic expect_quiet(input int n);
		for (int i = 0; i < n; i++) begin
			step();
			check_flag(bk_busy, 1'b0, "bk_busy with no transfer due");
			check_flag(cheat_clear, 1'b0, "cheat_clear outside a download");
		end
		if (req_log.size() != 0) begin
			$display("Host saw a sector request where no transfer was due");
			abort_run();
		end
	endtask

	task automatic nvram_writes(input int n);
		for (int i = 0; i < n; i++) begin
			nvram_we = 1'b1;
			step();
			nvram_we = 1'b0;
			idle_gap($unsigned($random(seed)) % 5);
		end
	endtask

	// Host acks 1 to 8 cycles after a request and holds ack for 1 to 4
	always begin
		@(posedge clk_sys);
		#1;
		if (ack_hold > 0) begin
			ack_hold--;
			if (ack_hold == 0)
				sd_ack = 1'b0;
		end else if (ack_delay > 0) begin
			ack_delay--;
			if (ack_delay == 0) begin
				sd_ack   = 1'b1;
				ack_hold = 1 + $unsigned($random(ack_seed)) % 4;
			end
		end else if (sd.rd || sd.wr) begin
			req_log.push_back(sd);
			ack_delay = 1 + $unsigned($random(ack_seed)) % 8;
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		ce_bus_t exp_ce;
		int      first[4];
		int      period[4];
		seed     = 32'hd00e6a4a;
		ack_seed = 32'hd00e6a4a;
		// Indexed by bit of ce_bus_t with sp at bit 0
		period = '{2, 10, 5, 15};
		RESET            = 1'b1;
		dl               = '0;
		img_mounted      = 1'b0;
		img_readonly     = 1'b0;
		img_size_nonzero = 1'b0;
		nvram_we         = 1'b0;
		osd_open         = 1'b0;
		autosave         = 1'b0;
		load_req         = 1'b0;
		save_req         = 1'b0;
		sd_ack           = 1'b0;
		repeat (5) step();
		check_ce(ce, '0, "enables in reset");
		RESET = 1'b0;

		// Enable periods and vdp coincidence
		for (int i = 0; i < 4; i++)
			first[i] = -1;
		for (int cyc = 0; cyc < 300; cyc++) begin
			step();
			for (int i = 0; i < 4; i++) begin
				if (first[i] < 0 && ce[i] === 1'b1)
					first[i] = cyc;
				exp_ce[i] = (first[i] >= 0) && (((cyc - first[i]) % period[i]) == 0);
			end
			check_ce(ce, exp_ce, "clock enable pattern");
			if (ce.cpu || ce.pix)
				check_flag(ce.vdp, 1'b1, "vdp with cpu or pix");
		end
		for (int i = 0; i < 4; i++) begin
			if (first[i] < 0 || first[i] >= `CE_CYCLE_LEN) begin
				$display("Clock enable bit %0d did not start within one frame", i);
				abort_run();
			end
		end

		// Three cheat records with random gaps
		download(`DL_INDEX_CHEAT, 3 * `CHEAT_RECORD_BYTES);
		idle_gap(3);

		// Cartridge download pulls the save image in
		img_mounted      = 1'b1;
		img_readonly     = 1'b0;
		img_size_nonzero = 1'b1;
		download(8'h01, 20);
		expect_transfer(1'b1);

		save_req = 1'b1;
		step();
		save_req = 1'b0;
		expect_transfer(1'b0);
		load_req = 1'b1;
		step();
		load_req = 1'b0;
		expect_transfer(1'b1);

		// Autosave on menu open
		autosave = 1'b1;
		nvram_writes(1 + $unsigned($random(seed)) % 6);
		check_flag(bk_pending, 1'b1, "bk_pending after nvram writes");
		osd_open = 1'b1;
		expect_transfer(1'b0);
		check_flag(bk_pending, 1'b0, "bk_pending after autosave");
		osd_open = 1'b0;
		autosave = 1'b0;
		nvram_writes(1 + $unsigned($random(seed)) % 6);
		osd_open = 1'b1;
		expect_quiet(40);
		check_flag(bk_pending, 1'b1, "bk_pending with autosave off");
		osd_open = 1'b0;

		// Read-only image leaves backup disabled
		img_readonly = 1'b1;
		download(8'h02, 8);
		expect_quiet(20);
		load_req = 1'b1;
		step();
		load_req = 1'b0;
		expect_quiet(20);
		save_req = 1'b1;
		step();
		save_req = 1'b0;
		expect_quiet(20);

		if (dut.u_assert.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
